// ==== src/gfx_params.svh ====
`ifndef GFX_PARAMS_SVH
`define GFX_PARAMS_SVH

// horizontal timing, pixels
`define H_ACTIVE 16
`define H_FP 2
`define H_SYNC 3
`define H_BP 3

// vertical timing, lines
`define V_ACTIVE 8
`define V_FP 1
`define V_SYNC 2
`define V_BP 1

// sram bus and colour widths
`define ADDR_BITS 20
`define DATA_BITS 16
`define COLOR_BITS 4

`endif

// ==== src/vga_pkg.sv ====
`default_nettype none

`include "gfx_params.svh"

package vga_pkg;

  localparam int H_TOTAL = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
  localparam int V_TOTAL = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
  localparam int X_BITS = $clog2(H_TOTAL);
  localparam int Y_BITS = $clog2(V_TOTAL);

  // scan position at one instant, syncs active low
  typedef struct packed {
    logic [X_BITS-1:0] x;
    logic [Y_BITS-1:0] y;
    logic              active;
    logic              hsync;
    logic              vsync;
  } scan_t;

endpackage

`default_nettype wire

// ==== src/gfx_pkg.sv ====
`default_nettype none

`include "gfx_params.svh"

package gfx_pkg;

  localparam int META_BITS = `DATA_BITS - 3 * `COLOR_BITS;

  typedef logic [META_BITS-1:0] frame_num_t;

  typedef struct packed {
    logic [`COLOR_BITS-1:0] red;
    logic [`COLOR_BITS-1:0] grn;
    logic [`COLOR_BITS-1:0] blu;
    logic                   de;
  } pixel_t;

  // frame buffer word layout, meta in the top nibble
  typedef struct packed {
    logic [META_BITS-1:0]   meta;
    logic [`COLOR_BITS-1:0] red;
    logic [`COLOR_BITS-1:0] grn;
    logic [`COLOR_BITS-1:0] blu;
  } mem_word_t;

endpackage

`default_nettype wire

// ==== src/sram_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gfx_params.svh"

// one asynchronous sram port, split data lines
interface sram_if;

  logic [`ADDR_BITS-1:0] addr;
  logic [`DATA_BITS-1:0] wdata;
  logic [`DATA_BITS-1:0] rdata;
  logic                  we_n;
  logic                  oe_n;
  logic                  ce_n;

  modport ctrl (output addr, wdata, we_n, oe_n, ce_n, input rdata);
  modport dev (input addr, wdata, we_n, oe_n, ce_n, output rdata);

endinterface

`default_nettype wire

// ==== src/scan_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gfx_params.svh"

module scan_timing (
  input  logic           clk,
  input  logic           rst_n,
  output vga_pkg::scan_t scan,
  output logic           frame_start
);

  localparam int XB = vga_pkg::X_BITS;
  localparam int YB = vga_pkg::Y_BITS;

  localparam logic [XB-1:0] H_ACT_END = XB'(`H_ACTIVE);
  localparam logic [XB-1:0] HS_BEG = XB'(`H_ACTIVE + `H_FP);
  localparam logic [XB-1:0] HS_END = XB'(`H_ACTIVE + `H_FP + `H_SYNC);
  localparam logic [XB-1:0] H_LAST = XB'(vga_pkg::H_TOTAL - 1);

  localparam logic [YB-1:0] V_ACT_END = YB'(`V_ACTIVE);
  localparam logic [YB-1:0] VS_BEG = YB'(`V_ACTIVE + `V_FP);
  localparam logic [YB-1:0] VS_END = YB'(`V_ACTIVE + `V_FP + `V_SYNC);
  localparam logic [YB-1:0] V_LAST = YB'(vga_pkg::V_TOTAL - 1);

  logic [XB-1:0] h_cnt;
  logic [YB-1:0] v_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == H_LAST) begin
      h_cnt <= '0;
      if (v_cnt == V_LAST) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign scan.x = h_cnt;
  assign scan.y = v_cnt;
  assign scan.active = (h_cnt < H_ACT_END) && (v_cnt < V_ACT_END);
  // sync windows, low while inside
  assign scan.hsync = !((h_cnt >= HS_BEG) && (h_cnt < HS_END));
  assign scan.vsync = !((v_cnt >= VS_BEG) && (v_cnt < VS_END));

  assign frame_start = (h_cnt == '0) && (v_cnt == '0);

endmodule

`default_nettype wire

// ==== src/pipe_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// single register stage for any packed payload
module pipe_stage #(
  parameter type      payload_t = logic,
  parameter payload_t RST_VAL   = '0
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      q <= RST_VAL;
    end else begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// ==== src/frame_painter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gfx_params.svh"

module frame_painter (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                painter_go,
  input  gfx_pkg::frame_num_t frame_num,
  output logic                painter_done,
  sram_if.ctrl                wr_port
);

  localparam int XB = $clog2(`H_ACTIVE);
  localparam int YB = $clog2(`V_ACTIVE);
  localparam int AB = `ADDR_BITS;
  localparam int CB = `COLOR_BITS;

  localparam logic [XB-1:0] X_LAST = XB'(`H_ACTIVE - 1);
  localparam logic [YB-1:0] Y_LAST = YB'(`V_ACTIVE - 1);

  logic                busy;
  logic [XB-1:0]       x;
  logic [YB-1:0]       y;
  gfx_pkg::frame_num_t frame_q;
  gfx_pkg::mem_word_t  word;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy         <= 1'b0;
      painter_done <= 1'b0;
      x            <= '0;
      y            <= '0;
    end else if (painter_go) begin
      busy         <= 1'b1;
      painter_done <= 1'b0;
      x            <= '0;
      y            <= '0;
    end else if (busy) begin
      if (x == X_LAST) begin
        x <= '0;
        if (y == Y_LAST) begin
          // last word written this cycle
          busy         <= 1'b0;
          painter_done <= 1'b1;
        end else begin
          y <= y + 1'b1;
        end
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (painter_go) begin
      frame_q <= frame_num;
    end
  end

  // test pattern
  assign word.meta = frame_q;
  assign word.red  = CB'(x);
  assign word.grn  = CB'(y);
  assign word.blu  = CB'(frame_q) + CB'(x);

  assign wr_port.addr  = AB'(y) * AB'(`H_ACTIVE) + AB'(x);
  assign wr_port.wdata = word;
  assign wr_port.we_n  = !busy;
  assign wr_port.ce_n  = !busy;
  assign wr_port.oe_n  = 1'b1;

endmodule

`default_nettype wire

// ==== src/buffer_swap.sv ====
`timescale 1ns/1ps
`default_nettype none

module buffer_swap (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                frame_start,
  input  logic                painter_done,
  sram_if.dev                 rd_port,
  sram_if.dev                 wr_port,
  sram_if.ctrl                sram0,
  sram_if.ctrl                sram1,
  output logic                painter_go,
  output gfx_pkg::frame_num_t frame_num,
  output logic                shown
);

  // 0 means sram0 is the front buffer
  logic front_sel;
  logic started;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      front_sel  <= 1'b0;
      started    <= 1'b0;
      shown      <= 1'b0;
      painter_go <= 1'b0;
      frame_num  <= '0;
    end else begin
      painter_go <= 1'b0;
      if (frame_start) begin
        if (!started) begin
          // first paint, nothing to show yet
          started    <= 1'b1;
          painter_go <= 1'b1;
        end else if (painter_done) begin
          front_sel  <= !front_sel;
          shown      <= 1'b1;
          frame_num  <= frame_num + 1'b1;
          painter_go <= 1'b1;
        end
      end
    end
  end

  // reader on the front, painter on the back
  always_comb begin
    if (!front_sel) begin
      sram0.addr    = rd_port.addr;
      sram0.wdata   = rd_port.wdata;
      sram0.we_n    = rd_port.we_n;
      sram0.oe_n    = rd_port.oe_n;
      sram0.ce_n    = rd_port.ce_n;
      sram1.addr    = wr_port.addr;
      sram1.wdata   = wr_port.wdata;
      sram1.we_n    = wr_port.we_n;
      sram1.oe_n    = wr_port.oe_n;
      sram1.ce_n    = wr_port.ce_n;
      rd_port.rdata = sram0.rdata;
      wr_port.rdata = sram1.rdata;
    end else begin
      sram1.addr    = rd_port.addr;
      sram1.wdata   = rd_port.wdata;
      sram1.we_n    = rd_port.we_n;
      sram1.oe_n    = rd_port.oe_n;
      sram1.ce_n    = rd_port.ce_n;
      sram0.addr    = wr_port.addr;
      sram0.wdata   = wr_port.wdata;
      sram0.we_n    = wr_port.we_n;
      sram0.oe_n    = wr_port.oe_n;
      sram0.ce_n    = wr_port.ce_n;
      rd_port.rdata = sram1.rdata;
      wr_port.rdata = sram0.rdata;
    end
  end

endmodule

`default_nettype wire

// ==== src/pixel_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gfx_params.svh"

module pixel_stage (
  input  logic            clk,
  input  logic            rst_n,
  input  vga_pkg::scan_t  scan,
  input  logic            shown,
  sram_if.ctrl            rd_port,
  output gfx_pkg::pixel_t pix,
  output logic            hsync,
  output logic            vsync
);

  localparam int AB = `ADDR_BITS;

  // syncs idle high out of reset
  localparam vga_pkg::scan_t SCAN_IDLE = '{
    x: '0,
    y: '0,
    active: 1'b0,
    hsync: 1'b1,
    vsync: 1'b1
  };

  vga_pkg::scan_t     scan_d1;
  gfx_pkg::mem_word_t word;
  gfx_pkg::pixel_t    pix_next;

  pipe_stage #(
    .payload_t(vga_pkg::scan_t),
    .RST_VAL  (SCAN_IDLE)
  ) u_scan_reg (
    .clk  (clk),
    .rst_n(rst_n),
    .d    (scan),
    .q    (scan_d1)
  );

  assign rd_port.addr  = AB'(scan_d1.y) * AB'(`H_ACTIVE) + AB'(scan_d1.x);
  assign rd_port.wdata = '0;
  assign rd_port.we_n  = 1'b1;
  assign rd_port.oe_n  = !scan_d1.active;
  assign rd_port.ce_n  = !scan_d1.active;

  // word comes back in the same cycle
  assign word = gfx_pkg::mem_word_t'(rd_port.rdata);

  always_comb begin
    pix_next.de = scan_d1.active;
    if (scan_d1.active && shown) begin
      pix_next.red = word.red;
      pix_next.grn = word.grn;
      pix_next.blu = word.blu;
    end else begin
      pix_next.red = '0;
      pix_next.grn = '0;
      pix_next.blu = '0;
    end
  end

  pipe_stage #(
    .payload_t(gfx_pkg::pixel_t)
  ) u_pix_reg (
    .clk  (clk),
    .rst_n(rst_n),
    .d    (pix_next),
    .q    (pix)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hsync <= 1'b1;
      vsync <= 1'b1;
    end else begin
      hsync <= scan_d1.hsync;
      vsync <= scan_d1.vsync;
    end
  end

endmodule

`default_nettype wire

// ==== src/gfx_dbuf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gfx_params.svh"

module gfx_dbuf_top (
  input  logic                   clk,
  input  logic                   rst_n,

  // sram 0
  output logic [`ADDR_BITS-1:0]  sram0_addr,
  output logic [`DATA_BITS-1:0]  sram0_wdata,
  input  logic [`DATA_BITS-1:0]  sram0_rdata,
  output logic                   sram0_we_n,
  output logic                   sram0_oe_n,
  output logic                   sram0_ce_n,

  // sram 1
  output logic [`ADDR_BITS-1:0]  sram1_addr,
  output logic [`DATA_BITS-1:0]  sram1_wdata,
  input  logic [`DATA_BITS-1:0]  sram1_rdata,
  output logic                   sram1_we_n,
  output logic                   sram1_oe_n,
  output logic                   sram1_ce_n,

  // vga
  output logic [`COLOR_BITS-1:0] vga_red,
  output logic [`COLOR_BITS-1:0] vga_grn,
  output logic [`COLOR_BITS-1:0] vga_blu,
  output logic                   vga_de,
  output logic                   vga_hsync,
  output logic                   vga_vsync
);

  vga_pkg::scan_t      scan;
  logic                frame_start;
  logic                painter_go;
  logic                painter_done;
  logic                shown;
  gfx_pkg::frame_num_t frame_num;
  gfx_pkg::pixel_t     pix;

  sram_if rd_bus ();
  sram_if wr_bus ();
  sram_if sram0_bus ();
  sram_if sram1_bus ();

  scan_timing u_scan_timing (
    .clk        (clk),
    .rst_n      (rst_n),
    .scan       (scan),
    .frame_start(frame_start)
  );

  frame_painter u_frame_painter (
    .clk         (clk),
    .rst_n       (rst_n),
    .painter_go  (painter_go),
    .frame_num   (frame_num),
    .painter_done(painter_done),
    .wr_port     (wr_bus.ctrl)
  );

  buffer_swap u_buffer_swap (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_start (frame_start),
    .painter_done(painter_done),
    .rd_port     (rd_bus.dev),
    .wr_port     (wr_bus.dev),
    .sram0       (sram0_bus.ctrl),
    .sram1       (sram1_bus.ctrl),
    .painter_go  (painter_go),
    .frame_num   (frame_num),
    .shown       (shown)
  );

  pixel_stage u_pixel_stage (
    .clk    (clk),
    .rst_n  (rst_n),
    .scan   (scan),
    .shown  (shown),
    .rd_port(rd_bus.ctrl),
    .pix    (pix),
    .hsync  (vga_hsync),
    .vsync  (vga_vsync)
  );

  assign sram0_addr      = sram0_bus.addr;
  assign sram0_wdata     = sram0_bus.wdata;
  assign sram0_we_n      = sram0_bus.we_n;
  assign sram0_oe_n      = sram0_bus.oe_n;
  assign sram0_ce_n      = sram0_bus.ce_n;
  assign sram0_bus.rdata = sram0_rdata;

  assign sram1_addr      = sram1_bus.addr;
  assign sram1_wdata     = sram1_bus.wdata;
  assign sram1_we_n      = sram1_bus.we_n;
  assign sram1_oe_n      = sram1_bus.oe_n;
  assign sram1_ce_n      = sram1_bus.ce_n;
  assign sram1_bus.rdata = sram1_rdata;

  assign vga_red = pix.red;
  assign vga_grn = pix.grn;
  assign vga_blu = pix.blu;
  assign vga_de  = pix.de;

endmodule

`default_nettype wire

// ==== test/gfx_dbuf_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module gfx_dbuf_properties (
  input logic clk,
  input logic rst_n,
  input logic sram0_we_n,
  input logic sram0_oe_n,
  input logic sram0_ce_n,
  input logic sram1_we_n,
  input logic sram1_oe_n,
  input logic sram1_ce_n,
  input logic vga_de,
  input logic vga_hsync,
  input logic vga_vsync
);

  // a written sram must not drive its data lines
  assert property (@(posedge clk) disable iff (!rst_n)
    !(!sram0_ce_n && !sram0_we_n && !sram0_oe_n))
    else $error("sram0 written with output enabled");

  assert property (@(posedge clk) disable iff (!rst_n)
    !(!sram1_ce_n && !sram1_we_n && !sram1_oe_n))
    else $error("sram1 written with output enabled");

  // only the back buffer takes writes
  assert property (@(posedge clk) disable iff (!rst_n)
    !(!sram0_ce_n && !sram0_we_n && !sram1_ce_n && !sram1_we_n))
    else $error("both srams written in one cycle");

  assert property (@(posedge clk) disable iff (!rst_n)
    (!vga_hsync || !vga_vsync) |-> !vga_de)
    else $error("vga_de high during a sync pulse");

endmodule

bind gfx_dbuf_top gfx_dbuf_properties u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .sram0_we_n(sram0_we_n),
  .sram0_oe_n(sram0_oe_n),
  .sram0_ce_n(sram0_ce_n),
  .sram1_we_n(sram1_we_n),
  .sram1_oe_n(sram1_oe_n),
  .sram1_ce_n(sram1_ce_n),
  .vga_de    (vga_de),
  .vga_hsync (vga_hsync),
  .vga_vsync (vga_vsync)
);

`default_nettype wire

// ==== test/tb_gfx_dbuf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gfx_params.svh"

module tb_gfx_dbuf;

  localparam int MEM_DEPTH = 256;
  localparam int PIXELS = `H_ACTIVE * `V_ACTIVE;
  localparam int LINE_CLKS = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
  localparam int FRAME_CLKS = LINE_CLKS * (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP);
  localparam int RUN_FRAMES = 7;
  localparam int T_RESET = 0;
  localparam int T_GEOM = 1;
  localparam int T_BLANK = 2;
  localparam int T_PATTERN = 3;
  localparam int T_ALTER = 4;
  localparam int T_WRITES = 5;
  localparam int N_TESTS = 6;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic [`ADDR_BITS-1:0]  sram0_addr;
  logic [`DATA_BITS-1:0]  sram0_wdata;
  logic [`DATA_BITS-1:0]  sram0_rdata;
  logic                   sram0_we_n;
  logic                   sram0_oe_n;
  logic                   sram0_ce_n;
  logic [`ADDR_BITS-1:0]  sram1_addr;
  logic [`DATA_BITS-1:0]  sram1_wdata;
  logic [`DATA_BITS-1:0]  sram1_rdata;
  logic                   sram1_we_n;
  logic                   sram1_oe_n;
  logic                   sram1_ce_n;
  logic [`COLOR_BITS-1:0] vga_red;
  logic [`COLOR_BITS-1:0] vga_grn;
  logic [`COLOR_BITS-1:0] vga_blu;
  logic                   vga_de;
  logic                   vga_hsync;
  logic                   vga_vsync;

  logic [`DATA_BITS-1:0] mem0 [MEM_DEPTH];
  logic [`DATA_BITS-1:0] mem1 [MEM_DEPTH];

  int       err_cnt [N_TESTS];
  int       chk_cnt [N_TESTS];
  int       hits [PIXELS];
  int       wr_cnt [2];
  int       cyc;
  int       frame_idx;
  int       pix_idx;
  int       de_run;
  int       lines;
  int       swaps;
  int       disp_num;
  int       last_hs = -1;
  int       last_vs = -1;
  bit       prev_hs = 1'b1;
  bit       prev_vs = 1'b1;
  bit       prev_de;
  bit       rd_ok_d;
  int       rd_sel_d;
  bit [3:0] rd_meta_d;
  bit [3:0] last_meta;

  always #20 clk = ~clk;

  gfx_dbuf_top u_gfx_dbuf_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .sram0_addr (sram0_addr),
    .sram0_wdata(sram0_wdata),
    .sram0_rdata(sram0_rdata),
    .sram0_we_n (sram0_we_n),
    .sram0_oe_n (sram0_oe_n),
    .sram0_ce_n (sram0_ce_n),
    .sram1_addr (sram1_addr),
    .sram1_wdata(sram1_wdata),
    .sram1_rdata(sram1_rdata),
    .sram1_we_n (sram1_we_n),
    .sram1_oe_n (sram1_oe_n),
    .sram1_ce_n (sram1_ce_n),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_de     (vga_de),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync)
  );

  // sram models, asynchronous read
  initial begin
    for (int i = 0; i < MEM_DEPTH; i++) begin
      mem0[i] = 16'(i * 40503) ^ 16'hc3a5;
      mem1[i] = 16'(i * 40503) ^ 16'h3c5a;
    end
  end

  always @(posedge clk) begin
    if (!sram0_ce_n && !sram0_we_n) begin
      mem0[sram0_addr[7:0]] <= sram0_wdata;
    end
    if (!sram1_ce_n && !sram1_we_n) begin
      mem1[sram1_addr[7:0]] <= sram1_wdata;
    end
  end

  assign sram0_rdata = (!sram0_ce_n && !sram0_oe_n) ? mem0[sram0_addr[7:0]] : '0;
  assign sram1_rdata = (!sram1_ce_n && !sram1_oe_n) ? mem1[sram1_addr[7:0]] : '0;

  // meta, red, green, blue of one painted word
  function automatic logic [15:0] expected_word(input int x, input int y, input int frame);
    logic [3:0] f;
    logic [3:0] px;
    f = 4'(frame);
    px = 4'(x);
    return {f, px, 4'(y), f + px};
  endfunction

  function automatic string test_name(input int t);
    case (t)
      T_RESET:   return "reset_state";
      T_GEOM:    return "frame_geometry";
      T_BLANK:   return "blank_before_swap";
      T_PATTERN: return "pattern_content";
      T_ALTER:   return "buffer_alternation";
      default:   return "write_traffic";
    endcase
  endfunction

  task automatic compare_value(input int t, input string sig, input int got, input int exp);
    chk_cnt[t]++;
    assert (got == exp) else begin
      err_cnt[t]++;
      $display("** Error at time %0t: %s = %0d, expected %0d", $time, sig, got, exp);
    end
  endtask

  task automatic require(input int t, input bit cond, input string what);
    chk_cnt[t]++;
    assert (cond) else begin
      err_cnt[t]++;
      $display("Error at time %0t: %s", $time, what);
    end
  endtask

  task automatic report_test(input int t);
    if (chk_cnt[t] == 0) begin
      err_cnt[t]++;
      $display("test %s ran no checks", test_name(t));
    end
    $display("test %s: %0d checks, %0d errors", test_name(t), chk_cnt[t], err_cnt[t]);
  endtask

  task automatic record_write(input int sel, input string sig, input int addr,
                              input logic [15:0] data);
    wr_cnt[sel]++;
    if (addr < PIXELS) begin
      hits[addr]++;
      compare_value(T_WRITES, sig, int'(data),
                    int'(expected_word(addr % `H_ACTIVE, addr / `H_ACTIVE, frame_idx)));
    end else begin
      require(T_WRITES, 1'b0, "painter wrote outside the frame area");
    end
  endtask

  task automatic check_pixel(input int x, input int y);
    logic [15:0] exp;
    require(T_PATTERN, rd_ok_d, "no sram read behind a displayed pixel");
    if (x == 0 && y == 0) begin
      // a new meta value in the front sram marks a swap
      if (swaps == 0 || rd_meta_d != last_meta) begin
        swaps++;
        last_meta = rd_meta_d;
      end
      disp_num = swaps - 1;
      compare_value(T_ALTER, "displayed frame", disp_num, frame_idx - 1);
      compare_value(T_ALTER, "vga_blu offset", int'(vga_blu), disp_num % 16);
      compare_value(T_ALTER, "front sram", rd_sel_d, frame_idx % 2);
    end
    exp = expected_word(x, y, disp_num);
    compare_value(T_PATTERN, "front meta", int'(rd_meta_d), int'(exp[15:12]));
    compare_value(T_PATTERN, "vga_red", int'(vga_red), int'(exp[11:8]));
    compare_value(T_PATTERN, "vga_grn", int'(vga_grn), int'(exp[7:4]));
    compare_value(T_PATTERN, "vga_blu", int'(vga_blu), int'(exp[3:0]));
  endtask

  task automatic close_frame();
    int exp_sel;
    int miss;
    // even paints land in sram1
    exp_sel = (frame_idx % 2 == 0) ? 1 : 0;
    compare_value(T_GEOM, "lines per frame", lines, `V_ACTIVE);
    compare_value(T_GEOM, "pixels per frame", pix_idx, PIXELS);
    compare_value(T_WRITES, "writes to the back sram", wr_cnt[exp_sel], PIXELS);
    compare_value(T_ALTER, "writes to the front sram", wr_cnt[1 - exp_sel], 0);
    miss = 0;
    for (int a = 0; a < PIXELS; a++) begin
      if (hits[a] != 1) begin
        miss++;
      end
      hits[a] = 0;
    end
    compare_value(T_WRITES, "addresses not written once", miss, 0);
    if (frame_idx == 0) begin
      report_test(T_BLANK);
    end
    frame_idx++;
    pix_idx = 0;
    lines = 0;
    wr_cnt[0] = 0;
    wr_cnt[1] = 0;
  endtask

  always @(negedge clk) begin : output_check
    cyc++;
    if (!rst_n) begin
      compare_value(T_RESET, "sram0_we_n", int'(sram0_we_n), 1);
      compare_value(T_RESET, "sram1_we_n", int'(sram1_we_n), 1);
      compare_value(T_RESET, "sram0_ce_n", int'(sram0_ce_n), 1);
      compare_value(T_RESET, "sram1_ce_n", int'(sram1_ce_n), 1);
      compare_value(T_RESET, "vga_hsync", int'(vga_hsync), 1);
      compare_value(T_RESET, "vga_vsync", int'(vga_vsync), 1);
      compare_value(T_RESET, "vga_de", int'(vga_de), 0);
    end else begin
      require(T_WRITES, sram0_we_n || sram0_ce_n || sram0_oe_n,
              "sram0 written while its output is enabled");
      require(T_WRITES, sram1_we_n || sram1_ce_n || sram1_oe_n,
              "sram1 written while its output is enabled");
      require(T_WRITES, sram0_we_n || sram0_ce_n || sram1_we_n || sram1_ce_n,
              "both srams written in one cycle");
      require(T_GEOM, !vga_de || (vga_hsync && vga_vsync), "vga_de high during a sync pulse");
      if (!sram0_ce_n && !sram0_we_n) begin
        record_write(0, "sram0_wdata", int'(sram0_addr), sram0_wdata);
      end
      if (!sram1_ce_n && !sram1_we_n) begin
        record_write(1, "sram1_wdata", int'(sram1_addr), sram1_wdata);
      end
      if (vga_de) begin
        if (frame_idx == 0) begin
          compare_value(T_BLANK, "vga_red", int'(vga_red), 0);
          compare_value(T_BLANK, "vga_grn", int'(vga_grn), 0);
          compare_value(T_BLANK, "vga_blu", int'(vga_blu), 0);
        end else begin
          check_pixel(pix_idx % `H_ACTIVE, pix_idx / `H_ACTIVE);
        end
        pix_idx++;
        de_run++;
      end else if (prev_de) begin
        compare_value(T_GEOM, "de run length", de_run, `H_ACTIVE);
        lines++;
        de_run = 0;
      end
      if (prev_hs && !vga_hsync) begin
        if (last_hs >= 0) begin
          compare_value(T_GEOM, "hsync period", cyc - last_hs, LINE_CLKS);
        end
        last_hs = cyc;
      end
      if (prev_vs && !vga_vsync) begin
        if (last_vs >= 0) begin
          compare_value(T_GEOM, "vsync period", cyc - last_vs, FRAME_CLKS);
        end
        last_vs = cyc;
        close_frame();
      end
    end
    // read behind the pixel that shows up next cycle
    rd_ok_d = 1'b1;
    if (!sram0_ce_n && !sram0_oe_n) begin
      rd_sel_d = 0;
      rd_meta_d = sram0_rdata[15:12];
    end else if (!sram1_ce_n && !sram1_oe_n) begin
      rd_sel_d = 1;
      rd_meta_d = sram1_rdata[15:12];
    end else begin
      rd_ok_d = 1'b0;
    end
    prev_hs = vga_hsync;
    prev_vs = vga_vsync;
    prev_de = vga_de;
  end

  initial begin : main
    int waited;
    int total_chk;
    int total_err;
    bit timed_out;
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    report_test(T_RESET);
    waited = 0;
    while (frame_idx < RUN_FRAMES && waited < (RUN_FRAMES + 1) * FRAME_CLKS) begin
      @(posedge clk);
      waited++;
    end
    timed_out = (frame_idx < RUN_FRAMES);
    if (timed_out) begin
      $display("timeout after %0d cycles, only %0d frames completed", waited, frame_idx);
    end
    report_test(T_GEOM);
    report_test(T_PATTERN);
    report_test(T_ALTER);
    report_test(T_WRITES);
    total_chk = 0;
    total_err = 0;
    for (int t = 0; t < N_TESTS; t++) begin
      total_chk += chk_cnt[t];
      total_err += err_cnt[t];
    end
    $display("total: %0d checks, %0d errors", total_chk, total_err);
    if (timed_out || total_err != 0) begin
      $display(">>> FAIL");
    end else begin
      $display(">>> PASS");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== gfx_dbuf_top.f ====
+incdir+src
src/vga_pkg.sv
src/gfx_pkg.sv
src/sram_if.sv
src/scan_timing.sv
src/pipe_stage.sv
src/frame_painter.sv
src/buffer_swap.sv
src/pixel_stage.sv
src/gfx_dbuf_top.sv
test/gfx_dbuf_properties.sv
test/tb_gfx_dbuf.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_gfx_dbuf -f gfx_dbuf_top.f --Mdir obj_dir -o tb_gfx_dbuf
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_gfx_dbuf +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx '>>> PASS' "$LOG"; then
  exit 0
fi
exit 1
